/* dcache_pkg.sv */
// ----------------------------------------------------------
// Data cache package
// Geometry of the two-way cache, address decode union,
// tag entry and request structs, controller state type
// ----------------------------------------------------------

package dcache_pkg;

   // Cache geometry
   localparam int num_ways        = 2;
   // 32-byte blocks
   localparam int block_width     = 5;
   // 64 sets
   localparam int set_width       = 6;
   localparam int words_per_block = 8;
   // Upper address bits left over above index and offset
   localparam int tag_width       = 32 - block_width - set_width;

   // Byte address split into cache fields
   typedef struct packed {
      logic [tag_width-1:0]     tag;
      logic [set_width-1:0]     index;
      logic [block_width-3:0]   word;
      logic [1:0]               byte_off;
   } adr_fields_t;

   // Same address seen flat or as fields
   typedef union packed {
      logic [31:0]  flat;
      adr_fields_t  f;
   } adr_u;

   // One tag memory entry
   typedef struct packed {
      logic                  valid;
      logic [tag_width-1:0]  tag;
   } tag_entry_t;

   // CPU load/store request, held until ack
   typedef struct packed {
      adr_u          adr;
      logic          we;
      logic [3:0]    bsel;
      logic [31:0]   wdata;
   } cpu_req_t;

   // Commands from the controller, shared by every way
   typedef struct packed {
      logic [set_width-1:0]    rd_index;
      logic [block_width-3:0]  rd_word;
      logic [set_width-1:0]    wr_index;
      logic [block_width-3:0]  wr_word;
      logic [31:0]             wdata;
      tag_entry_t              tag_wentry;
      logic [tag_width-1:0]    cmp_tag;
   } way_ctl_t;

   // Controller states
   typedef enum logic [2:0] {
      st_idle,
      st_lookup,
      st_write,
      st_refill,
      st_inval
   } cache_state_t;

endpackage

/* dcache_way.sv */
// ----------------------------------------------------------
// Data cache way
// Tag and data arrays of one way with synchronous read,
// per-set valid register and tag compare for hit
// ----------------------------------------------------------

`timescale 1ns/100ps

module dcache_way (
   input  logic                    clk,
   input  logic                    rst,
   input  dcache_pkg::way_ctl_t    way_ctl_i,
   input  logic                    data_we_i,
   input  logic                    tag_we_i,
   output logic                    hit_o,
   output logic [31:0]             rdata_o,
   output dcache_pkg::tag_entry_t  entry_o
);

   localparam int num_sets  = 2 ** dcache_pkg::set_width;
   localparam int num_words = num_sets * dcache_pkg::words_per_block;

   // Tag bits live in RAM, valid bits in flops so reset can clear them
   logic [dcache_pkg::tag_width-1:0]  tag_mem [num_sets];
   logic [31:0]                       data_mem [num_words];
   logic [num_sets-1:0]               valid_q;

   logic [dcache_pkg::tag_width-1:0]  tag_rd_q;
   logic                              valid_rd_q;
   logic [31:0]                       data_rd_q;

   // Tag and data RAMs, read every cycle at the read address
   always_ff @(posedge clk) begin
      if (tag_we_i) begin
         tag_mem[way_ctl_i.wr_index] <= way_ctl_i.tag_wentry.tag;
      end
      if (data_we_i) begin
         data_mem[{way_ctl_i.wr_index, way_ctl_i.wr_word}] <= way_ctl_i.wdata;
      end
      tag_rd_q  <= tag_mem[way_ctl_i.rd_index];
      data_rd_q <= data_mem[{way_ctl_i.rd_index, way_ctl_i.rd_word}];
   end

   // Valid flags, all sets cleared on reset
   always_ff @(posedge clk) begin
      if (rst) begin
         valid_q    <= '0;
         valid_rd_q <= 1'b0;
      end else begin
         if (tag_we_i) begin
            valid_q[way_ctl_i.wr_index] <= way_ctl_i.tag_wentry.valid;
         end
         valid_rd_q <= valid_q[way_ctl_i.rd_index];
      end
   end

   assign entry_o.valid = valid_rd_q;
   assign entry_o.tag   = tag_rd_q;
   assign rdata_o       = data_rd_q;

   // Hit only on a valid entry with matching tag
   assign hit_o = valid_rd_q && (tag_rd_q == way_ctl_i.cmp_tag);

endmodule

/* dcache_ctrl.sv */
// ----------------------------------------------------------
// Data cache controller
// FSM for lookup, write hit merge, block refill and
// invalidate; drives the shared way commands and enables
// ----------------------------------------------------------

`timescale 1ns/100ps

module dcache_ctrl (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                req_i,
   input  dcache_pkg::cpu_req_t                cpu_req_i,
   input  logic                                any_hit_i,
   input  logic [dcache_pkg::num_ways-1:0]     hit_way_i,
   input  logic [dcache_pkg::num_ways-1:0]     victim_i,
   input  logic [31:0]                         sel_rdata_i,
   input  logic                                refill_we_i,
   input  logic [31:0]                         refill_dat_i,
   input  logic                                inv_stb_i,
   input  dcache_pkg::adr_u                    inv_adr_i,
   output dcache_pkg::way_ctl_t                way_ctl_o,
   output logic [dcache_pkg::num_ways-1:0]     data_we_o,
   output logic [dcache_pkg::num_ways-1:0]     tag_we_o,
   output logic                                lru_we_o,
   output logic [dcache_pkg::num_ways-1:0]     lru_touch_o,
   output logic                                ack_o,
   output logic                                refill_req_o,
   output logic [31:0]                         refill_adr_o,
   output logic                                inv_ack_o
);

   localparam int word_w = dcache_pkg::block_width - 2;

   dcache_pkg::cache_state_t             state_q;
   dcache_pkg::cache_state_t             state_d;
   logic [word_w-1:0]                    cnt_q;
   logic [dcache_pkg::num_ways-1:0]      victim_q;
   logic                                 start_fill;
   logic                                 last_word;
   logic [31:0]                          merged;
   dcache_pkg::adr_u                     fill_adr;

   // Old bytes where the select is off, CPU bytes where it is on
   always_comb begin
      for (int b = 0; b < 4; b++) begin
         merged[8*b +: 8] = cpu_req_i.bsel[b] ? cpu_req_i.wdata[8*b +: 8]
                                              : sel_rdata_i[8*b +: 8];
      end
   end

   // Block aligned refill address
   always_comb begin
      fill_adr            = cpu_req_i.adr;
      fill_adr.f.word     = '0;
      fill_adr.f.byte_off = '0;
   end
   assign refill_adr_o = fill_adr.flat;

   assign last_word = (cnt_q == word_w'(dcache_pkg::words_per_block - 1));

   always_comb begin
      state_d      = state_q;
      start_fill   = 1'b0;
      data_we_o    = '0;
      tag_we_o     = '0;
      lru_we_o     = 1'b0;
      lru_touch_o  = hit_way_i;
      ack_o        = 1'b0;
      inv_ack_o    = 1'b0;
      refill_req_o = 1'b0;

      // Arrays always read at the held CPU address
      way_ctl_o.rd_index         = cpu_req_i.adr.f.index;
      way_ctl_o.rd_word          = cpu_req_i.adr.f.word;
      way_ctl_o.wr_index         = cpu_req_i.adr.f.index;
      way_ctl_o.wr_word          = cpu_req_i.adr.f.word;
      way_ctl_o.wdata            = merged;
      way_ctl_o.tag_wentry.valid = 1'b0;
      way_ctl_o.tag_wentry.tag   = cpu_req_i.adr.f.tag;
      way_ctl_o.cmp_tag          = cpu_req_i.adr.f.tag;

      case (state_q)
         dcache_pkg::st_idle: begin
            // Invalidate wins over a CPU request
            if (inv_stb_i) begin
               state_d = dcache_pkg::st_inval;
            end else if (req_i) begin
               state_d = dcache_pkg::st_lookup;
            end
         end

         dcache_pkg::st_lookup: begin
            if (any_hit_i && cpu_req_i.we) begin
               state_d = dcache_pkg::st_write;
            end else if (any_hit_i || cpu_req_i.we) begin
               // Read hit, or write miss that leaves the cache alone
               ack_o    = 1'b1;
               lru_we_o = any_hit_i;
               state_d  = dcache_pkg::st_idle;
            end else begin
               // Read miss, drop the victim line before refilling it
               tag_we_o   = victim_i;
               start_fill = 1'b1;
               state_d    = dcache_pkg::st_refill;
            end
         end

         dcache_pkg::st_write: begin
            data_we_o = hit_way_i;
            lru_we_o  = 1'b1;
            ack_o     = 1'b1;
            state_d   = dcache_pkg::st_idle;
         end

         dcache_pkg::st_refill: begin
            refill_req_o       = 1'b1;
            way_ctl_o.wr_word  = cnt_q;
            way_ctl_o.wdata    = refill_dat_i;
            if (refill_we_i) begin
               data_we_o = victim_q;
               // Last word also validates the tag and marks the way recent
               if (last_word) begin
                  tag_we_o                   = victim_q;
                  way_ctl_o.tag_wentry.valid = 1'b1;
                  lru_we_o                   = 1'b1;
                  lru_touch_o                = victim_q;
                  state_d                    = dcache_pkg::st_idle;
               end
            end
         end

         dcache_pkg::st_inval: begin
            // Clear the set in every way
            way_ctl_o.wr_index = inv_adr_i.f.index;
            tag_we_o           = '1;
            inv_ack_o          = 1'b1;
            state_d            = dcache_pkg::st_idle;
         end

         default: begin
            state_d = dcache_pkg::st_idle;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q  <= dcache_pkg::st_idle;
         cnt_q    <= '0;
         victim_q <= '0;
      end else begin
         state_q <= state_d;
         if (start_fill) begin
            victim_q <= victim_i;
            cnt_q    <= '0;
         end else if (state_q == dcache_pkg::st_refill && refill_we_i) begin
            cnt_q <= cnt_q + 1'b1;
         end
      end
   end

endmodule

/* dcache_way_select.sv */
// ----------------------------------------------------------
// Data cache way select
// Hit data mux, one LRU bit per set and victim choice
// ----------------------------------------------------------

`timescale 1ns/100ps

module dcache_way_select (
   input  logic                                              clk,
   input  logic                                              rst,
   input  logic [dcache_pkg::num_ways-1:0]                   hit_i,
   input  logic [dcache_pkg::num_ways-1:0][31:0]             rdata_i,
   input  dcache_pkg::tag_entry_t [dcache_pkg::num_ways-1:0] entry_i,
   input  logic [dcache_pkg::set_width-1:0]                  rd_index_i,
   input  logic [dcache_pkg::set_width-1:0]                  wr_index_i,
   input  logic                                              lru_we_i,
   input  logic [dcache_pkg::num_ways-1:0]                   lru_touch_i,
   output logic                                              any_hit_o,
   output logic [dcache_pkg::num_ways-1:0]                   hit_way_o,
   output logic [dcache_pkg::num_ways-1:0]                   victim_o,
   output logic [31:0]                                       rdata_o
);

   // Per set, the number of the least recently used way
   logic [2**dcache_pkg::set_width-1:0]  lru_q;

   assign any_hit_o = |hit_i;
   assign hit_way_o = hit_i;

   // Hit is one-hot, so an AND-OR mux is enough
   always_comb begin
      rdata_o = '0;
      for (int w = 0; w < dcache_pkg::num_ways; w++) begin
         if (hit_i[w]) begin
            rdata_o = rdata_o | rdata_i[w];
         end
      end
   end

   // LRU way, but an empty way is filled first
   always_comb begin
      victim_o = '0;
      victim_o[lru_q[rd_index_i]] = 1'b1;
      for (int w = dcache_pkg::num_ways - 1; w >= 0; w--) begin
         if (!entry_i[w].valid) begin
            victim_o    = '0;
            victim_o[w] = 1'b1;
         end
      end
   end

   // Touching way 0 makes way 1 the LRU and the other way round
   always_ff @(posedge clk) begin
      if (rst) begin
         lru_q <= '0;
      end else if (lru_we_i) begin
         lru_q[wr_index_i] <= lru_touch_i[0];
      end
   end

endmodule

/* dcache_top.sv */
// ----------------------------------------------------------
// Data cache top level
// Two-way set-associative cache: controller, ways and
// way select wired together
// ----------------------------------------------------------

`timescale 1ns/100ps

module dcache_top (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  req_i,
   input  dcache_pkg::cpu_req_t  cpu_req_i,
   output logic                  ack_o,
   output logic [31:0]           rdata_o,
   output logic                  refill_req_o,
   output logic [31:0]           refill_adr_o,
   input  logic                  refill_we_i,
   input  logic [31:0]           refill_dat_i,
   input  logic                  inv_stb_i,
   input  dcache_pkg::adr_u      inv_adr_i,
   output logic                  inv_ack_o
);

   dcache_pkg::way_ctl_t                              way_ctl;
   logic [dcache_pkg::num_ways-1:0]                   data_we;
   logic [dcache_pkg::num_ways-1:0]                   tag_we;
   logic [dcache_pkg::num_ways-1:0]                   way_hit;
   logic [dcache_pkg::num_ways-1:0][31:0]             way_rdata;
   dcache_pkg::tag_entry_t [dcache_pkg::num_ways-1:0] way_entry;
   logic                                              any_hit;
   logic [dcache_pkg::num_ways-1:0]                   hit_way;
   logic [dcache_pkg::num_ways-1:0]                   victim;
   logic                                              lru_we;
   logic [dcache_pkg::num_ways-1:0]                   lru_touch;

   dcache_ctrl u_ctrl (
      .clk          (clk),
      .rst          (rst),
      .req_i        (req_i),
      .cpu_req_i    (cpu_req_i),
      .any_hit_i    (any_hit),
      .hit_way_i    (hit_way),
      .victim_i     (victim),
      .sel_rdata_i  (rdata_o),
      .refill_we_i  (refill_we_i),
      .refill_dat_i (refill_dat_i),
      .inv_stb_i    (inv_stb_i),
      .inv_adr_i    (inv_adr_i),
      .way_ctl_o    (way_ctl),
      .data_we_o    (data_we),
      .tag_we_o     (tag_we),
      .lru_we_o     (lru_we),
      .lru_touch_o  (lru_touch),
      .ack_o        (ack_o),
      .refill_req_o (refill_req_o),
      .refill_adr_o (refill_adr_o),
      .inv_ack_o    (inv_ack_o)
   );

   // One way per slot, all sharing the controller commands
   for (genvar i = 0; i < dcache_pkg::num_ways; i++) begin : gen_way
      dcache_way u_way (
         .clk       (clk),
         .rst       (rst),
         .way_ctl_i (way_ctl),
         .data_we_i (data_we[i]),
         .tag_we_i  (tag_we[i]),
         .hit_o     (way_hit[i]),
         .rdata_o   (way_rdata[i]),
         .entry_o   (way_entry[i])
      );
   end

   dcache_way_select u_sel (
      .clk         (clk),
      .rst         (rst),
      .hit_i       (way_hit),
      .rdata_i     (way_rdata),
      .entry_i     (way_entry),
      .rd_index_i  (way_ctl.rd_index),
      .wr_index_i  (way_ctl.wr_index),
      .lru_we_i    (lru_we),
      .lru_touch_i (lru_touch),
      .any_hit_o   (any_hit),
      .hit_way_o   (hit_way),
      .victim_o    (victim),
      .rdata_o     (rdata_o)
   );

endmodule

/* dcache_props.sv */
// ----------------------------------------------------------
// Data cache controller properties
// Acknowledge exclusion, refill request hold, reset quiet
// ----------------------------------------------------------

`timescale 1ns/100ps

module dcache_props (
   input logic  clk,
   input logic  rst,
   input logic  ack_o,
   input logic  inv_ack_o,
   input logic  refill_req_o,
   input logic  refill_we_i,
   input logic  last_word
);

   // CPU and invalidate acks never together
   ack_excl: assert property (@(posedge clk) !(ack_o && inv_ack_o))
      else $error("ack_o and inv_ack_o high together");

   // Request held until the eighth strobe
   fill_hold: assert property (@(posedge clk) disable iff (rst)
      (refill_req_o && !(refill_we_i && last_word)) |=> refill_req_o)
      else $error("refill_req_o dropped before the last strobe");

   // No ack while reset is applied
   rst_quiet: assert property (@(posedge clk) rst |-> !ack_o)
      else $error("ack_o high during reset");

endmodule

bind dcache_ctrl dcache_props u_props (
   .clk          (clk),
   .rst          (rst),
   .ack_o        (ack_o),
   .inv_ack_o    (inv_ack_o),
   .refill_req_o (refill_req_o),
   .refill_we_i  (refill_we_i),
   .last_word    (last_word)
);

/* tb_checker.sv */
// ----------------------------------------------------------
// Data cache checker
// Watches the DUT ports, keeps a reference memory model and
// compares read data, hit latency and refill traffic
// ----------------------------------------------------------

`timescale 1ns/100ps

module tb_checker (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  req_i,
   input  dcache_pkg::cpu_req_t  cpu_req_i,
   input  logic                  ack_i,
   input  logic [31:0]           rdata_i,
   input  logic                  refill_req_i,
   input  logic [31:0]           refill_adr_i,
   input  logic                  refill_we_i,
   input  logic [1:0]            expect_i,
   output int                    checks_o,
   output int                    errors_o
);

   // Words written by the CPU, everything else is still at its reset value
   logic [31:0]  model [logic [29:0]];
   logic         in_req;
   logic         fill_seen;
   logic         fill_q;
   int           lat;
   int           strobes;

   // Expected memory word for a byte address
   function automatic logic [31:0] ref_word(input logic [31:0] adr);
      if (model.exists(adr[31:2])) begin
         return model[adr[31:2]];
      end
      return ~{2'b00, adr[31:2]};
   endfunction

   // Byte-select write into the model
   function automatic void model_write(input dcache_pkg::cpu_req_t r);
      logic [31:0] w;
      w = ref_word(r.adr.flat);
      for (int b = 0; b < 4; b++) begin
         if (r.bsel[b]) begin
            w[8*b +: 8] = r.wdata[8*b +: 8];
         end
      end
      model[r.adr.flat[31:2]] = w;
   endfunction

   always @(posedge clk) begin
      if (rst) begin
         in_req    = 1'b0;
         fill_seen = 1'b0;
         fill_q    = 1'b0;
         lat       = 0;
         strobes   = 0;
         checks_o  = 0;
         errors_o  = 0;
      end else begin
         // Refill port, block aligned address and eight strobes
         if (refill_req_i) begin
            fill_seen = 1'b1;
            if (refill_we_i) begin
               strobes++;
            end
            if (refill_adr_i !== {cpu_req_i.adr.flat[31:5], 5'b0}) begin
               $display("Error at %0t: refill_adr_o = %h, expected %h", $time,
                        refill_adr_i, {cpu_req_i.adr.flat[31:5], 5'b0});
               errors_o++;
            end
         end
         if (fill_q && !refill_req_i) begin
            checks_o++;
            if (strobes != 8) begin
               $display("Error at %0t: refill strobes = %0d, expected 8", $time, strobes);
               errors_o++;
            end
            strobes = 0;
         end
         fill_q = refill_req_i;

         // Request tracking from the first sampled req edge to ack
         if (in_req) begin
            lat++;
            if (ack_i) begin
               in_req = 1'b0;
               checks_o++;
               if (cpu_req_i.we) begin
                  model_write(cpu_req_i);
               end else if (rdata_i !== ref_word(cpu_req_i.adr.flat)) begin
                  $display("Error at %0t: rdata_o = %h, expected %h", $time,
                           rdata_i, ref_word(cpu_req_i.adr.flat));
                  errors_o++;
               end
               if (expect_i == 2'd1 && (fill_seen || lat != 2)) begin
                  $display("Expected a 2 cycle hit at %0t, got %0d cycles with refill %0b",
                           $time, lat, fill_seen);
                  errors_o++;
               end
               if (expect_i == 2'd2 && !fill_seen) begin
                  $display("Expected a refill at %0t but the read hit in the cache", $time);
                  errors_o++;
               end
            end
         end else if (req_i) begin
            in_req    = 1'b1;
            fill_seen = 1'b0;
            lat       = 1;
         end
      end
   end

endmodule

/* tb_top.sv */
// ----------------------------------------------------------
// Data cache testbench
// Clock, reset, LFSR driven CPU traffic, refill memory model
// and the DUT with its checker
// ----------------------------------------------------------

`timescale 1ns/100ps

module tb_top;

   localparam int n_ops       = 82;
   localparam int cycle_limit = 40 * n_ops;
   localparam int tag_w       = dcache_pkg::tag_width;

   logic                  clk;
   logic                  rst;
   logic                  req;
   dcache_pkg::cpu_req_t  cpu_req;
   logic                  ack;
   logic [31:0]           rdata;
   logic                  refill_req;
   logic [31:0]           refill_adr;
   logic                  refill_we;
   logic [31:0]           refill_dat;
   logic                  inv_stb;
   dcache_pkg::adr_u      inv_adr;
   logic                  inv_ack;
   // 0 no latency check, 1 hit expected, 2 refill expected
   logic [1:0]            expect_mode;
   int                    checks;
   int                    errors;
   int                    err_prev;
   int                    cycles;
   logic [15:0]           lfsr;
   logic [31:0]           shadow [logic [29:0]];
   dcache_pkg::adr_u      a;
   logic [31:0]           v;
   logic [31:0]           d;

   dcache_top dut (
      .clk          (clk),
      .rst          (rst),
      .req_i        (req),
      .cpu_req_i    (cpu_req),
      .ack_o        (ack),
      .rdata_o      (rdata),
      .refill_req_o (refill_req),
      .refill_adr_o (refill_adr),
      .refill_we_i  (refill_we),
      .refill_dat_i (refill_dat),
      .inv_stb_i    (inv_stb),
      .inv_adr_i    (inv_adr),
      .inv_ack_o    (inv_ack)
   );

   tb_checker chk (
      .clk          (clk),
      .rst          (rst),
      .req_i        (req),
      .cpu_req_i    (cpu_req),
      .ack_i        (ack),
      .rdata_i      (rdata),
      .refill_req_i (refill_req),
      .refill_adr_i (refill_adr),
      .refill_we_i  (refill_we),
      .expect_i     (expect_mode),
      .checks_o     (checks),
      .errors_o     (errors)
   );

   always #20 clk = ~clk;

   // Run limit
   always @(posedge clk) begin
      cycles++;
      if (cycles > cycle_limit) begin
         $display("Timeout after %0d cycles, the cache stopped answering", cycles);
         $display("Testbench failed");
         $finish;
      end
   end

   // Memory word whose reset value is the inverted word address
   function automatic logic [31:0] shadow_rd(input logic [29:0] w);
      if (shadow.exists(w)) begin
         return shadow[w];
      end
      return ~{2'b00, w};
   endfunction

   // Galois LFSR stepped once for every bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] bits;
      bits = '0;
      for (int i = 0; i < n; i++) begin
         lfsr    = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
         bits[i] = lfsr[0];
      end
      return bits;
   endfunction

   // Three tags over four sets
   task automatic rand_adr(output dcache_pkg::adr_u adr);
      logic [31:0] t;
      logic [31:0] s;
      logic [31:0] w;
      t = take_bits(2);
      s = take_bits(2);
      w = take_bits(3);
      adr.f.tag      = tag_w'(t % 3 + 1);
      adr.f.index    = {4'b0101, s[1:0]};
      adr.f.word     = w[2:0];
      adr.f.byte_off = 2'b00;
   endtask

   task automatic cpu_op(input logic [31:0] adr, input logic we, input logic [3:0] bsel,
                         input logic [31:0] wdata, input logic [1:0] mode);
      logic [31:0] w;
      @(negedge clk);
      cpu_req.adr.flat = adr;
      cpu_req.we       = we;
      cpu_req.bsel     = bsel;
      cpu_req.wdata    = wdata;
      expect_mode      = mode;
      req              = 1'b1;
      do begin
         @(negedge clk);
      end while (!ack);
      req = 1'b0;
      // Write-through memory gets every CPU write
      if (we) begin
         w = shadow_rd(adr[31:2]);
         for (int b = 0; b < 4; b++) begin
            if (bsel[b]) begin
               w[8*b +: 8] = wdata[8*b +: 8];
            end
         end
         shadow[adr[31:2]] = w;
      end
   endtask

   task automatic inval_op(input logic [31:0] adr);
      @(negedge clk);
      inv_adr.flat = adr;
      inv_stb      = 1'b1;
      do begin
         @(negedge clk);
      end while (!inv_ack);
      inv_stb = 1'b0;
   endtask

   task automatic end_test(input int num, input string name);
      // Let the checker see the last ack of the test
      @(negedge clk);
      $display("Test %0d %s done, %0d errors", num, name, errors - err_prev);
      err_prev = errors;
   endtask

   // Refill memory returns words in order with uneven gaps
   initial begin
      forever begin
         @(negedge clk);
         if (refill_req && !rst) begin
            for (int k = 0; k < 8; k++) begin
               repeat (k % 3) @(negedge clk);
               refill_dat = shadow_rd(refill_adr[31:2] + 30'(k));
               refill_we  = 1'b1;
               @(negedge clk);
               refill_we  = 1'b0;
            end
         end
      end
   end

   initial begin
      clk         = 1'b0;
      rst         = 1'b1;
      req         = 1'b0;
      cpu_req     = '0;
      refill_we   = 1'b0;
      refill_dat  = '0;
      inv_stb     = 1'b0;
      inv_adr     = '0;
      expect_mode = 2'd0;
      err_prev    = 0;
      cycles      = 0;
      lfsr        = 16'd65;
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      for (int i = 0; i < 20; i++) begin
         rand_adr(a);
         cpu_op(a.flat, 1'b0, 4'h0, 32'h0, 2'd0);
      end
      end_test(1, "random reads");

      for (int i = 0; i < 4; i++) begin
         rand_adr(a);
         cpu_op(a.flat, 1'b0, 4'h0, 32'h0, 2'd0);
         cpu_op(a.flat, 1'b0, 4'h0, 32'h0, 2'd1);
      end
      end_test(2, "hit repetition");

      // Three tags through one emptied set so the first comes back evicted
      for (int s = 0; s < 4; s++) begin
         rand_adr(a);
         a.f.index = {4'b0101, 2'(s)};
         inval_op(a.flat);
         for (int t = 0; t < 4; t++) begin
            a.f.tag = tag_w'(t % 3 + 1);
            cpu_op(a.flat, 1'b0, 4'h0, 32'h0, 2'd2);
         end
      end
      end_test(3, "refill and eviction");

      for (int i = 0; i < 6; i++) begin
         rand_adr(a);
         d = take_bits(32);
         v = take_bits(4);
         if (v[3:0] == 4'h0 || v[3:0] == 4'hF) begin
            v[3:0] = 4'b0101;
         end
         cpu_op(a.flat, 1'b0, 4'h0, 32'h0, 2'd0);
         cpu_op(a.flat, 1'b1, v[3:0], d, 2'd0);
         cpu_op(a.flat, 1'b0, 4'h0, 32'h0, 2'd1);
      end
      end_test(4, "write merge");

      for (int i = 0; i < 4; i++) begin
         rand_adr(a);
         cpu_op(a.flat, 1'b0, 4'h0, 32'h0, 2'd0);
         cpu_op(a.flat, 1'b0, 4'h0, 32'h0, 2'd1);
         inval_op(a.flat);
         cpu_op(a.flat, 1'b0, 4'h0, 32'h0, 2'd2);
      end
      end_test(5, "invalidate");

      repeat (2) @(negedge clk);
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

/* compile.f */
dcache_pkg.sv
dcache_way.sv
dcache_ctrl.sv
dcache_way_select.sv
dcache_top.sv
dcache_props.sv
tb_checker.sv
tb_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the data cache testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_top -f compile.f -o tb_sim
./obj_dir/tb_sim > sim.log
cat sim.log
if grep -q "Testbench passed" sim.log; then
   exit 0
fi
exit 1
